// File: rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Datapath and register file geometry
`define XLEN		32
`define NREGS		32
`define REG_AW		5

// Operand a select, carried in alu_sel[5:3]
`define SEL_RS1		3'd0
`define SEL_PC		3'd1
`define SEL_ZERO	3'd2

// Operand b select, carried in alu_sel[2:0]
`define SEL_RS2		3'd0
`define SEL_IMM		3'd1
`define SEL_FOUR	3'd2

// ALU functions
`define ALU_ADD		5'd0
`define ALU_SUB		5'd1
`define ALU_SLL		5'd2
`define ALU_SLT		5'd3
`define ALU_SLTU	5'd4
`define ALU_XOR		5'd5
`define ALU_SRL		5'd6
`define ALU_SRA		5'd7
`define ALU_OR		5'd8
`define ALU_AND		5'd9
`define ALU_MUL		5'd10
`define ALU_MULH	5'd11
`define ALU_MULHSU	5'd12
`define ALU_MULHU	5'd13
// Decoder output for anything it does not know
`define ALU_NONE	5'd31

// Major opcodes handled by the decoder
`define OPC_OP		7'b0110011
`define OPC_OP_IMM	7'b0010011
`define OPC_LUI		7'b0110111
`define OPC_AUIPC	7'b0010111

`endif

// File: rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

	// Register-register layout
	typedef struct packed {
		logic [6:0]		funct7;
		logic [4:0]		rs2;
		logic [4:0]		rs1;
		logic [2:0]		funct3;
		logic [4:0]		rd;
		logic [6:0]		opcode;
	} r_fmt_t;

	// Immediate layout, also the base for the upper-immediate forms
	typedef struct packed {
		logic [11:0]	imm12;
		logic [4:0]		rs1;
		logic [2:0]		funct3;
		logic [4:0]		rd;
		logic [6:0]		opcode;
	} i_fmt_t;

	// Same instruction word, two readings
	typedef union packed {
		r_fmt_t	r;
		i_fmt_t	i;
	} instr_u;

	// Operation handed from decode to execute
	typedef struct packed {
		logic [`XLEN-1:0]	rs1_data;
		logic [`XLEN-1:0]	rs2_data;
		logic [`XLEN-1:0]	pc;
		logic [`XLEN-1:0]	imm;
		// Operand a select in [5:3], operand b select in [2:0]
		logic [5:0]			alu_sel;
		logic [4:0]			alu_func;
		logic [`REG_AW-1:0]	rd;
	} ex_op_t;

endpackage

// File: id_ex_if.sv
`timescale 1ns/1ps
`include "rv_params.svh"

interface id_ex_if import rv_pkg::*; ();

	// Forward handshake carrying one decoded operation
	logic				valid;
	logic				ready;
	ex_op_t				op;
	logic [`XLEN-1:0]	op_pc;

	// Destination of the result still held in execute
	logic				pend_valid;
	logic [`REG_AW-1:0]	pend_rd;

	modport issue (
		output	valid,
		output	op,
		output	op_pc,
		input	ready,
		input	pend_valid,
		input	pend_rd
	);

	modport exec (
		input	valid,
		input	op,
		input	op_pc,
		output	ready,
		output	pend_valid,
		output	pend_rd
	);

endinterface

// File: reg_file.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module reg_file (
	input	logic					clk,
	input	logic					rst_n,

	input	logic [`REG_AW-1:0]		rd_addr_a,
	input	logic [`REG_AW-1:0]		rd_addr_b,
	output	logic [`XLEN-1:0]		rd_data_a,
	output	logic [`XLEN-1:0]		rd_data_b,

	input	logic					wr_en,
	input	logic [`REG_AW-1:0]		wr_addr,
	input	logic [`XLEN-1:0]		wr_data
);

	logic [`XLEN-1:0] regs [0:`NREGS-1];

	// Entry 0 is cleared and never written again
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Combinational reads, x0 forced to zero
	always_comb begin
		if (rd_addr_a == '0)
			rd_data_a = '0;
		else
			rd_data_a = regs[rd_addr_a];
		if (rd_addr_b == '0)
			rd_data_b = '0;
		else
			rd_data_b = regs[rd_addr_b];
	end

endmodule

// File: id_stage.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module id_stage import rv_pkg::*; (
	input	logic					clk,
	input	logic					rst_n,

	input	logic					instr_valid,
	output	logic					instr_ready,
	input	instr_u					instr,
	input	logic [`XLEN-1:0]		pc,

	output	logic [`REG_AW-1:0]		rs1_addr,
	output	logic [`REG_AW-1:0]		rs2_addr,
	input	logic [`XLEN-1:0]		rs1_data,
	input	logic [`XLEN-1:0]		rs2_data,

	id_ex_if.issue					ex_if
);

	ex_op_t		dec_op;
	logic		use_rs1, use_rs2;
	logic		supported, held_sup;
	logic		hz_rs1, hz_rs2, hazard;
	logic		take;

	assign rs1_addr = instr.r.rs1;
	assign rs2_addr = instr.r.rs2;

	always_comb begin
		dec_op.rs1_data	= rs1_data;
		dec_op.rs2_data	= rs2_data;
		dec_op.pc		= pc;
		dec_op.rd		= instr.r.rd;
		dec_op.imm		= {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
		dec_op.alu_sel	= {`SEL_RS1, `SEL_RS2};
		dec_op.alu_func	= `ALU_NONE;
		use_rs1			= 1'b0;
		use_rs2			= 1'b0;
		case (instr.r.opcode)
			`OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				case ({instr.r.funct7, instr.r.funct3})
					{7'h00, 3'b000}:	dec_op.alu_func = `ALU_ADD;
					{7'h20, 3'b000}:	dec_op.alu_func = `ALU_SUB;
					{7'h00, 3'b001}:	dec_op.alu_func = `ALU_SLL;
					{7'h00, 3'b010}:	dec_op.alu_func = `ALU_SLT;
					{7'h00, 3'b011}:	dec_op.alu_func = `ALU_SLTU;
					{7'h00, 3'b100}:	dec_op.alu_func = `ALU_XOR;
					{7'h00, 3'b101}:	dec_op.alu_func = `ALU_SRL;
					{7'h20, 3'b101}:	dec_op.alu_func = `ALU_SRA;
					{7'h00, 3'b110}:	dec_op.alu_func = `ALU_OR;
					{7'h00, 3'b111}:	dec_op.alu_func = `ALU_AND;
					{7'h01, 3'b000}:	dec_op.alu_func = `ALU_MUL;
					{7'h01, 3'b001}:	dec_op.alu_func = `ALU_MULH;
					{7'h01, 3'b010}:	dec_op.alu_func = `ALU_MULHSU;
					{7'h01, 3'b011}:	dec_op.alu_func = `ALU_MULHU;
					default:			dec_op.alu_func = `ALU_NONE;
				endcase
			end
			`OPC_OP_IMM: begin
				use_rs1 = 1'b1;
				dec_op.alu_sel = {`SEL_RS1, `SEL_IMM};
				case (instr.i.funct3)
					3'b000:	dec_op.alu_func = `ALU_ADD;
					3'b010:	dec_op.alu_func = `ALU_SLT;
					3'b011:	dec_op.alu_func = `ALU_SLTU;
					3'b100:	dec_op.alu_func = `ALU_XOR;
					3'b110:	dec_op.alu_func = `ALU_OR;
					3'b111:	dec_op.alu_func = `ALU_AND;
					// Shift forms keep funct7 in the top of imm12
					3'b001: begin
						if (instr.r.funct7 == 7'h00)
							dec_op.alu_func = `ALU_SLL;
					end
					default: begin
						if (instr.r.funct7 == 7'h00)
							dec_op.alu_func = `ALU_SRL;
						else if (instr.r.funct7 == 7'h20)
							dec_op.alu_func = `ALU_SRA;
					end
				endcase
			end
			`OPC_LUI, `OPC_AUIPC: begin
				dec_op.imm = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'h000};
				dec_op.alu_func = `ALU_ADD;
				if (instr.r.opcode == `OPC_LUI)
					dec_op.alu_sel = {`SEL_ZERO, `SEL_IMM};
				else
					dec_op.alu_sel = {`SEL_PC, `SEL_IMM};
			end
			default: dec_op.alu_func = `ALU_NONE;
		endcase
	end

	// Interlock against the held entry and the result waiting in execute
	assign supported	= (dec_op.alu_func != `ALU_NONE);
	assign held_sup		= ex_if.valid && (ex_if.op.alu_func != `ALU_NONE);
	assign hz_rs1 = use_rs1 && (rs1_addr != '0) &&
		((held_sup && (rs1_addr == ex_if.op.rd)) ||
		 (ex_if.pend_valid && (rs1_addr == ex_if.pend_rd)));
	assign hz_rs2 = use_rs2 && (rs2_addr != '0) &&
		((held_sup && (rs2_addr == ex_if.op.rd)) ||
		 (ex_if.pend_valid && (rs2_addr == ex_if.pend_rd)));
	assign hazard = supported && (hz_rs1 || hz_rs2);

	assign instr_ready	= (!ex_if.valid || ex_if.ready) && !hazard;
	assign take			= instr_valid && instr_ready;

	always_ff @(posedge clk) begin
		if (!rst_n)
			ex_if.valid <= 1'b0;
		else if (take)
			ex_if.valid <= 1'b1;
		else if (ex_if.ready)
			ex_if.valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			ex_if.op	<= dec_op;
			ex_if.op_pc	<= pc;
		end
	end

endmodule

// File: ex_stage.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module ex_stage (
	input	logic					clk,
	input	logic					rst_n,

	id_ex_if.exec					ex_if,

	output	logic					result_valid,
	input	logic					result_ready,
	output	logic [`XLEN-1:0]		result_data,
	output	logic [`REG_AW-1:0]		result_rd,
	output	logic [`XLEN-1:0]		result_pc,

	output	logic					wr_en,
	output	logic [`REG_AW-1:0]		wr_addr,
	output	logic [`XLEN-1:0]		wr_data
);

	logic [`XLEN-1:0]	opa, opb;
	logic [`XLEN-1:0]	alu_res;
	logic				alu_ok;
	logic				sign_a, sign_b;
	logic signed [`XLEN:0]		mul_a, mul_b;
	logic signed [2*`XLEN+1:0]	mul_res;

	always_comb begin
		case (ex_if.op.alu_sel[5:3])
			`SEL_RS1:	opa = ex_if.op.rs1_data;
			`SEL_PC:	opa = ex_if.op.pc;
			default:	opa = '0;
		endcase
		case (ex_if.op.alu_sel[2:0])
			`SEL_RS2:	opb = ex_if.op.rs2_data;
			`SEL_IMM:	opb = ex_if.op.imm;
			`SEL_FOUR:	opb = `XLEN'd4;
			default:	opb = '0;
		endcase
	end

	// Extra top bit is the sign when signed, zero otherwise
	assign sign_b	= (ex_if.op.alu_func == `ALU_MULH);
	assign sign_a	= sign_b || (ex_if.op.alu_func == `ALU_MULHSU);
	assign mul_a	= {sign_a && opa[`XLEN-1], opa};
	assign mul_b	= {sign_b && opb[`XLEN-1], opb};
	assign mul_res	= mul_a * mul_b;

	always_comb begin
		alu_res	= '0;
		alu_ok	= 1'b1;
		case (ex_if.op.alu_func)
			`ALU_ADD:		alu_res = opa + opb;
			`ALU_SUB:		alu_res = opa - opb;
			`ALU_SLL:		alu_res = opa << opb[4:0];
			`ALU_SLT:		alu_res = {{(`XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
			`ALU_SLTU:		alu_res = {{(`XLEN-1){1'b0}}, opa < opb};
			`ALU_XOR:		alu_res = opa ^ opb;
			`ALU_SRL:		alu_res = opa >> opb[4:0];
			`ALU_SRA:		alu_res = $signed(opa) >>> opb[4:0];
			`ALU_OR:		alu_res = opa | opb;
			`ALU_AND:		alu_res = opa & opb;
			`ALU_MUL:		alu_res = mul_res[`XLEN-1:0];
			`ALU_MULH,
			`ALU_MULHSU,
			`ALU_MULHU:		alu_res = mul_res[2*`XLEN-1:`XLEN];
			// Unknown function is swallowed without a result
			default:		alu_ok = 1'b0;
		endcase
	end

	assign ex_if.ready = !result_valid || result_ready;

	always_ff @(posedge clk) begin
		if (!rst_n)
			result_valid <= 1'b0;
		else if (ex_if.valid && ex_if.ready && alu_ok)
			result_valid <= 1'b1;
		else if (result_ready)
			result_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (ex_if.valid && ex_if.ready && alu_ok) begin
			result_data	<= alu_res;
			result_rd	<= ex_if.op.rd;
			result_pc	<= ex_if.op_pc;
		end
	end

	// Destination still owed to the register file
	assign ex_if.pend_valid	= result_valid;
	assign ex_if.pend_rd	= result_rd;

	// Write back on the result handshake
	assign wr_en	= result_valid && result_ready;
	assign wr_addr	= result_rd;
	assign wr_data	= result_data;

endmodule

// File: rv_exec_top.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_exec_top import rv_pkg::*; (
	input	logic					clk,
	input	logic					rst_n,

	input	logic					instr_valid,
	output	logic					instr_ready,
	input	instr_u					instr,
	input	logic [`XLEN-1:0]		pc,

	output	logic					result_valid,
	input	logic					result_ready,
	output	logic [`XLEN-1:0]		result_data,
	output	logic [`REG_AW-1:0]		result_rd,
	output	logic [`XLEN-1:0]		result_pc
);

	logic [`REG_AW-1:0]		rs1_addr, rs2_addr;
	logic [`XLEN-1:0]		rs1_data, rs2_data;
	logic					wr_en;
	logic [`REG_AW-1:0]		wr_addr;
	logic [`XLEN-1:0]		wr_data;

	id_ex_if id_ex ();

	reg_file u_reg_file (
		.clk			(clk),
		.rst_n			(rst_n),
		.rd_addr_a		(rs1_addr),
		.rd_addr_b		(rs2_addr),
		.rd_data_a		(rs1_data),
		.rd_data_b		(rs2_data),
		.wr_en			(wr_en),
		.wr_addr		(wr_addr),
		.wr_data		(wr_data)
	);

	id_stage u_id_stage (
		.clk			(clk),
		.rst_n			(rst_n),
		.instr_valid	(instr_valid),
		.instr_ready	(instr_ready),
		.instr			(instr),
		.pc				(pc),
		.rs1_addr		(rs1_addr),
		.rs2_addr		(rs2_addr),
		.rs1_data		(rs1_data),
		.rs2_data		(rs2_data),
		.ex_if			(id_ex.issue)
	);

	ex_stage u_ex_stage (
		.clk			(clk),
		.rst_n			(rst_n),
		.ex_if			(id_ex.exec),
		.result_valid	(result_valid),
		.result_ready	(result_ready),
		.result_data	(result_data),
		.result_rd		(result_rd),
		.result_pc		(result_pc),
		.wr_en			(wr_en),
		.wr_addr		(wr_addr),
		.wr_data		(wr_data)
	);

endmodule

// File: rv_exec_assert.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_exec_assert (
	input	logic					clk,
	input	logic					rst_n,
	input	logic					instr_valid,
	input	logic					instr_ready,
	input	logic [`XLEN-1:0]		instr,
	input	logic [`XLEN-1:0]		pc,
	input	logic					result_valid,
	input	logic					result_ready,
	input	logic [`XLEN-1:0]		result_data,
	input	logic [`REG_AW-1:0]		result_rd,
	input	logic [`XLEN-1:0]		result_pc
);

	// Offered instruction stays put until taken
	a_instr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid && !instr_ready |=> instr_valid && $stable(instr) && $stable(pc))
		else $error("instruction changed or dropped before it was accepted");

	// Offered result stays put until taken
	a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid && !result_ready |=> result_valid && $stable(result_data) &&
		$stable(result_rd) && $stable(result_pc))
		else $error("result changed or dropped before it was taken");

	a_reset_idle: assert property (@(posedge clk) !rst_n |=> !result_valid)
		else $error("result_valid high in the cycle after reset");

	a_rd_range: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid && result_ready |-> !$isunknown(result_rd))
		else $error("result delivered with an invalid destination register");

endmodule

// File: tb_rv_exec.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_exec import rv_pkg::*; ();

	// Instruction counts per test phase
	localparam int N_ALU	= 40;
	localparam int N_MULR	= 16;
	localparam int N_UPPER	= 8;
	localparam int N_DEP	= 60;
	localparam int N_BAD	= 6;
	localparam int N_LAT	= 24;
	localparam int N_TOTAL	= 62 + 2 * N_ALU + 5 + 96 + N_MULR + 2 * N_UPPER + N_DEP +
		2 * N_BAD + N_LAT;
	// Dependent stalls plus back-pressure stay well under ten cycles each
	localparam int TIMEOUT_CYCLES = 10 * N_TOTAL + 100;

	typedef struct packed {
		logic [`XLEN-1:0]	data;
		logic [`REG_AW-1:0]	rd;
		logic [`XLEN-1:0]	pc;
		int					cyc;
		logic				lat;
	} exp_t;

	logic					clk;
	logic					rst_n;
	logic					instr_valid;
	logic					instr_ready;
	instr_u					instr;
	logic [`XLEN-1:0]		pc;
	logic					result_valid;
	logic					result_ready;
	logic [`XLEN-1:0]		result_data;
	logic [`REG_AW-1:0]		result_rd;
	logic [`XLEN-1:0]		result_pc;

	integer				seed = 32'hdb68_edfd;
	integer				ready_seed = 32'hdb68_edfd;
	logic [`XLEN-1:0]	mregs [0:`NREGS-1];
	exp_t				exp_q [$];
	exp_t				e;
	logic [`XLEN-1:0]	mon_res;
	logic [`XLEN-1:0]	pc_cur = 32'h0000_1000;
	logic [31:0]		ready_bits;
	logic				rand_ready = 1'b0;
	logic				lat_mode = 1'b0;
	int					cyc = 0;
	int					errors = 0;
	int					checks = 0;
	int					n_results = 0;
	int					n_expected = 0;

	rv_exec_top uut (
		.clk			(clk),
		.rst_n			(rst_n),
		.instr_valid	(instr_valid),
		.instr_ready	(instr_ready),
		.instr			(instr),
		.pc				(pc),
		.result_valid	(result_valid),
		.result_ready	(result_ready),
		.result_data	(result_data),
		.result_rd		(result_rd),
		.result_pc		(result_pc)
	);

	bind rv_exec_top rv_exec_assert u_assert (
		.clk			(clk),
		.rst_n			(rst_n),
		.instr_valid	(instr_valid),
		.instr_ready	(instr_ready),
		.instr			(instr),
		.pc				(pc),
		.result_valid	(result_valid),
		.result_ready	(result_ready),
		.result_data	(result_data),
		.result_rd		(result_rd),
		.result_pc		(result_pc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] rnd();
		rnd = $random(seed);
	endfunction

	function automatic logic [4:0] rand_reg();
		logic [31:0] r;
		r = rnd();
		return 5'(1 + r % 31);
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	// Base integer operations by funct3, alt picks SUB or SRA
	function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [`XLEN-1:0] x, input logic [`XLEN-1:0] y);
		logic [`XLEN-1:0] v;
		case (f3)
			3'd0: v = alt ? x - y : x + y;
			3'd1: v = x << y[4:0];
			3'd2: v = {31'b0, $signed(x) < $signed(y)};
			3'd3: v = {31'b0, x < y};
			3'd4: v = x ^ y;
			3'd5: begin
				if (alt)
					v = $signed(x) >>> y[4:0];
				else
					v = x >> y[4:0];
			end
			3'd6: v = x | y;
			default: v = x & y;
		endcase
		return v;
	endfunction

	// RV32IM result of one word against the model registers, 0 when unsupported
	function automatic logic ref_exec(input logic [31:0] w, input logic [`XLEN-1:0] pcv,
			output logic [`XLEN-1:0] res);
		logic [`XLEN-1:0]	a, b, imm;
		logic [2*`XLEN-1:0]	sa, sb, za, zb, prod;
		logic [6:0]			f7;
		logic [2:0]			f3;
		logic				ok;
		f7 = w[31:25];
		f3 = w[14:12];
		a = mregs[w[19:15]];
		b = mregs[w[24:20]];
		imm = {{(`XLEN-12){w[31]}}, w[31:20]};
		sa = {{`XLEN{a[`XLEN-1]}}, a};
		sb = {{`XLEN{b[`XLEN-1]}}, b};
		za = {{`XLEN{1'b0}}, a};
		zb = {{`XLEN{1'b0}}, b};
		ok = 1'b1;
		res = '0;
		case (w[6:0])
			7'b0110111: res = {w[31:12], 12'h000};
			7'b0010111: res = pcv + {w[31:12], 12'h000};
			7'b0110011: begin
				if (f7 == 7'h01) begin
					case (f3)
						3'd0: begin
							prod = za * zb;
							res = prod[`XLEN-1:0];
						end
						3'd1: begin
							prod = sa * sb;
							res = prod[2*`XLEN-1:`XLEN];
						end
						3'd2: begin
							prod = sa * zb;
							res = prod[2*`XLEN-1:`XLEN];
						end
						3'd3: begin
							prod = za * zb;
							res = prod[2*`XLEN-1:`XLEN];
						end
						default: ok = 1'b0;
					endcase
				end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
					res = alu_ref(f3, f7[5], a, b);
				else
					ok = 1'b0;
			end
			7'b0010011: begin
				if (f3 == 3'd1 && f7 != 7'h00)
					ok = 1'b0;
				else if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)
					ok = 1'b0;
				else
					res = alu_ref(f3, (f3 == 3'd5) && f7[5], a, imm);
			end
			default: ok = 1'b0;
		endcase
		return ok;
	endfunction

	task automatic check_word(input string name, input logic [`XLEN-1:0] got,
			input logic [`XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_rd(input string name, input logic [`REG_AW-1:0] got,
			input logic [`REG_AW-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// Called just after a rising edge, returns just after the accepting edge
	task automatic issue_instr(input logic [31:0] w);
		instr_valid = 1'b1;
		instr = w;
		pc = pc_cur;
		@(negedge clk);
		while (!instr_ready)
			@(negedge clk);
		@(posedge clk);
		#1;
		pc_cur = pc_cur + 4;
	endtask

	task automatic wait_drain();
		instr_valid = 1'b0;
		@(negedge clk);
		while (exp_q.size() != 0 || result_valid)
			@(negedge clk);
		@(posedge clk);
		#1;
	endtask

	// Result ready, random only in the back-pressure phases
	always @(posedge clk) begin
		#1;
		ready_bits = $random(ready_seed);
		result_ready = rand_ready ? ready_bits[0] : 1'b1;
	end

	// Both handshakes sampled half a cycle before the edge that completes them
	always @(negedge clk) begin
		if (rst_n) begin
			if (result_valid && result_ready) begin
				n_results++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected result at %0t with no instruction outstanding", $time);
				end else begin
					e = exp_q.pop_front();
					check_word("result_data", result_data, e.data);
					check_rd("result_rd", result_rd, e.rd);
					check_word("result_pc", result_pc, e.pc);
					if (e.lat)
						check_count("latency", cyc - e.cyc, 2);
				end
			end
			if (instr_valid && instr_ready) begin
				if (ref_exec(instr, pc, mon_res)) begin
					exp_q.push_back('{mon_res, instr.r.rd, pc, cyc, lat_mode});
					n_expected++;
					if (instr.r.rd != '0)
						mregs[instr.r.rd] = mon_res;
				end
			end
		end
	end

	initial begin
		while (cyc < TIMEOUT_CYCLES)
			@(posedge clk);
		errors++;
		$display("timeout after %0d cycles with %0d results outstanding", cyc, exp_q.size());
		$display("Finished with errors");
		$finish;
	end

	initial begin
		logic [31:0]	r;
		logic [4:0]		rd;
		logic [4:0]		prev_rd;
		logic [6:0]		f7;
		logic [2:0]		f3;
		logic [11:0]	imm;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		result_ready = 1'b1;
		for (int i = 0; i < `NREGS; i++)
			mregs[i] = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Random contents for x1..x31 through LUI and ADDI
		for (int i = 1; i < 32; i++) begin
			r = rnd();
			issue_instr(enc_u(r[31:12], 5'(i), `OPC_LUI));
			issue_instr(enc_i(r[11:0], 5'(i), 3'd0, 5'(i), `OPC_OP_IMM));
		end

		// Register and immediate ALU forms
		repeat (N_ALU) begin
			r = rnd();
			f3 = r[2:0];
			f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[3]) ? 7'h20 : 7'h00;
			issue_instr(enc_r(f7, r[8:4], r[13:9], f3, rand_reg()));
			r = rnd();
			f3 = r[2:0];
			imm = r[31:20];
			if (f3 == 3'd1)
				imm[11:5] = 7'h00;
			else if (f3 == 3'd5)
				imm[11:5] = r[3] ? 7'h20 : 7'h00;
			issue_instr(enc_i(imm, r[8:4], f3, rand_reg(), `OPC_OP_IMM));
		end

		// Signed edges in x1..x4 for multiplies and compares
		issue_instr(enc_u(20'h80000, 5'd1, `OPC_LUI));
		issue_instr(enc_i(12'hfff, 5'd0, 3'd0, 5'd2, `OPC_OP_IMM));
		issue_instr(enc_i(12'h001, 5'd0, 3'd0, 5'd3, `OPC_OP_IMM));
		issue_instr(enc_u(20'h80000, 5'd4, `OPC_LUI));
		issue_instr(enc_i(12'hfff, 5'd4, 3'd0, 5'd4, `OPC_OP_IMM));
		for (int a = 1; a <= 4; a++) begin
			for (int b = 1; b <= 4; b++) begin
				for (int k = 0; k < 6; k++) begin
					r = rnd();
					rd = 5'(5 + r % 27);
					if (k < 4)
						issue_instr(enc_r(7'h01, 5'(b), 5'(a), 3'(k), rd));
					else
						issue_instr(enc_r(7'h00, 5'(b), 5'(a), 3'(k - 2), rd));
				end
			end
		end
		repeat (N_MULR) begin
			r = rnd();
			issue_instr(enc_r(7'h01, r[4:0], r[9:5], {1'b0, r[11:10]}, rand_reg()));
		end

		// Upper immediates at random pc values
		repeat (N_UPPER) begin
			r = rnd();
			pc_cur = {r[31:2], 2'b00};
			r = rnd();
			issue_instr(enc_u(r[19:0], rand_reg(), `OPC_LUI));
			issue_instr(enc_u(r[31:12], rand_reg(), `OPC_AUIPC));
		end

		// Dependent chain under back-pressure, x0 destinations included
		rand_ready = 1'b1;
		prev_rd = 5'd1;
		repeat (N_DEP) begin
			r = rnd();
			rd = {2'b00, r[2:0]};
			if (r[15:13] == 3'd7)
				issue_instr(enc_i(r[31:20], prev_rd, 3'd0, rd, `OPC_OP_IMM));
			else if (r[15:13] == 3'd6)
				issue_instr(enc_r(7'h01, r[12:8], prev_rd, {1'b0, r[17:16]}, rd));
			else begin
				f3 = r[18:16];
				f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[19]) ? 7'h20 : 7'h00;
				issue_instr(enc_r(f7, r[12:8], prev_rd, f3, rd));
			end
			prev_rd = rd;
		end

		// Unsupported words, each followed by a reader of its rd
		for (int k = 0; k < N_BAD; k++) begin
			case (k)
				0: issue_instr(enc_i(12'h004, 5'd1, 3'd2, 5'd9, 7'b0000011));
				1: issue_instr({7'h00, 5'd2, 5'd1, 3'd2, 5'd9, 7'b0100011});
				2: issue_instr({7'h00, 5'd2, 5'd1, 3'd0, 5'd9, 7'b1100011});
				3: issue_instr(enc_r(7'h01, 5'd2, 5'd1, 3'd4, 5'd9));
				4: issue_instr(enc_r(7'h20, 5'd2, 5'd1, 3'd1, 5'd9));
				default: issue_instr(enc_i({7'h20, 5'd3}, 5'd1, 3'd1, 5'd9, `OPC_OP_IMM));
			endcase
			issue_instr(enc_r(7'h00, 5'd1, 5'd9, 3'd0, 5'd9));
		end

		// Independent stream at full rate for the latency check
		rand_ready = 1'b0;
		wait_drain();
		lat_mode = 1'b1;
		for (int k = 0; k < N_LAT; k++) begin
			r = rnd();
			issue_instr(enc_i(r[11:0], 5'd0, 3'd0, 5'(1 + k % 31), `OPC_OP_IMM));
		end
		wait_drain();
		lat_mode = 1'b0;

		check_count("result count", n_results, n_expected);
		$display("results=%0d expected=%0d checks=%0d errors=%0d",
			n_results, n_expected, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: src.f
+incdir+.
rv_pkg.sv
id_ex_if.sv
reg_file.sv
id_stage.sv
ex_stage.sv
rv_exec_top.sv
rv_exec_assert.sv
tb_rv_exec.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_exec -f src.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1
